// ==== Bender.yml ====
package:
  name: div_unit

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rv_div_pkg.sv
      - design/div_core_pkg.sv
      - design/div_operand_prep.sv
      - design/div_unsigned_core.sv
      - design/div_result_fix.sv
      - design/div_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_div_unit.sv

// ==== design/div_cfg.svh ====
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// Operand and result width in bits.
`define DIV_XLEN 32

// Destination register tag width.
`define DIV_TAG_W 5

`endif

// ==== design/div_core_pkg.sv ====
`default_nettype none
`include "div_cfg.svh"

package div_core_pkg;

    // Magnitudes handed to the unsigned core.
    typedef struct packed {
        logic [`DIV_XLEN-1:0] dividend_mag;
        logic [`DIV_XLEN-1:0] divisor_mag;
    } div_job_t;

    // Carried alongside the job and applied to the core outputs.
    typedef struct packed {
        logic                  neg_quot;
        logic                  neg_rem;
        logic                  want_rem;
        logic [`DIV_TAG_W-1:0] tag;
    } div_fix_t;

    // Divider FSM states.
    typedef enum logic [2:0] {
        IDLE,
        DIVIDE,
        DONE,
        DONE_ERROR
    } core_state_e;

endpackage

`default_nettype wire

// ==== design/div_operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_operand_prep
    import rv_div_pkg::*;
    import div_core_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               start,
    input  wire  div_req_t    req,
    output logic              ready,
    input  wire  logic        core_ready,
    output logic              job_valid,
    output div_job_t          job,
    output div_fix_t          fix
);

    localparam int XLEN = `DIV_XLEN;

    logic            accept;
    logic            handover;
    logic            is_signed;
    logic            sign_a;
    logic            sign_b;
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;

    assign handover = job_valid && core_ready;
    assign ready    = !job_valid || core_ready;  // Free now or drains this edge.
    assign accept   = start && ready;

    // ########################################################################
    // Sign stripping
    // ########################################################################

    assign is_signed = (req.op == OP_DIV) || (req.op == OP_REM);
    assign sign_a    = is_signed && req.dividend[XLEN-1];
    assign sign_b    = is_signed && req.divisor[XLEN-1];
    assign mag_a     = sign_a ? -req.dividend : req.dividend;  // INT_MIN stays 2^31.
    assign mag_b     = sign_b ? -req.divisor : req.divisor;

    // ########################################################################
    // One-entry request register
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            job_valid <= 1'b0;
        end else if (accept) begin
            job_valid <= 1'b1;
        end else if (handover) begin
            job_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            job.dividend_mag <= mag_a;
            job.divisor_mag  <= mag_b;
            fix.neg_quot     <= (req.op == OP_DIV) && (sign_a ^ sign_b);
            fix.neg_rem      <= (req.op == OP_REM) && sign_a;
            fix.want_rem     <= (req.op == OP_REM) || (req.op == OP_REMU);
            fix.tag          <= req.tag;
        end
    end

    // A waiting entry stays put until the core takes it.
    a_hold_until_taken: assert property (
        @(posedge clk) disable iff (rst)
        job_valid && !core_ready |=> job_valid && $stable(job) && $stable(fix)
    );

endmodule

`default_nettype wire

// ==== design/div_result_fix.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_result_fix
    import rv_div_pkg::*;
    import div_core_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       valid,
    input  wire                       error,
    input  wire  [`DIV_XLEN-1:0]      quotient,
    input  wire  [`DIV_XLEN-1:0]      remainder,
    input  wire  div_fix_t            fix,
    output logic                      done,
    output div_resp_t                 resp
);

    localparam int XLEN = `DIV_XLEN;

    logic [XLEN-1:0] quot_fixed;
    logic [XLEN-1:0] rem_fixed;
    logic [XLEN-1:0] sel_result;

    // ########################################################################
    // RISC-V sign rules
    // ########################################################################

    // Divide by zero keeps the all-ones quotient whatever the signs.
    assign quot_fixed = (fix.neg_quot && !error) ? -quotient : quotient;

    // Remainder follows the dividend, which also restores it on a zero divisor.
    assign rem_fixed  = fix.neg_rem ? -remainder : remainder;

    assign sel_result = fix.want_rem ? rem_fixed : quot_fixed;

    // ########################################################################
    // Response register
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            resp.tag      <= fix.tag;
            resp.result   <= sel_result;
            resp.div_zero <= error;
        end
    end

    // A zero divisor arrives from the core as an all-ones quotient.
    a_error_all_ones: assert property (
        @(posedge clk) disable iff (rst) error |-> (quotient == '1)
    );

endmodule

`default_nettype wire

// ==== design/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_unit
    import rv_div_pkg::*;
    import div_core_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               start,
    input  wire  div_req_t    req,
    output logic              ready,
    output logic              done,
    output div_resp_t         resp
);

    logic                  core_ready;
    logic                  job_valid;
    div_job_t              job;
    div_fix_t              fix_to_core;
    div_fix_t              fix_from_core;
    logic                  core_valid;
    logic                  core_error;
    logic [`DIV_XLEN-1:0]  quotient;
    logic [`DIV_XLEN-1:0]  remainder;

    div_operand_prep prep0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .req        (req),
        .ready      (ready),
        .core_ready (core_ready),
        .job_valid  (job_valid),
        .job        (job),
        .fix        (fix_to_core)
    );

    div_unsigned_core core0 (
        .clk        (clk),
        .rst        (rst),
        .start      (job_valid),
        .ready      (core_ready),
        .valid      (core_valid),
        .error      (core_error),
        .job        (job),
        .fix_in     (fix_to_core),
        .fix_out    (fix_from_core),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    div_result_fix fix0 (
        .clk        (clk),
        .rst        (rst),
        .valid      (core_valid),
        .error      (core_error),
        .quotient   (quotient),
        .remainder  (remainder),
        .fix        (fix_from_core),
        .done       (done),
        .resp       (resp)
    );

endmodule

`default_nettype wire

// ==== design/div_unsigned_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_unsigned_core
    import div_core_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,
    output logic                      ready,
    output logic                      valid,
    output logic                      error,
    input  wire  div_job_t            job,
    input  wire  div_fix_t            fix_in,
    output div_fix_t                  fix_out,
    output logic [`DIV_XLEN-1:0]      quotient,
    output logic [`DIV_XLEN-1:0]      remainder
);

    localparam int XLEN = `DIV_XLEN;

    core_state_e       state;
    logic [XLEN:0]     count;            // One-hot, top bit marks the check cycle.
    logic [2*XLEN-1:0] shifted_divisor;
    logic [XLEN-1:0]   divisor_q;
    logic              check_cycle;
    logic              fits;

    assign ready = (state == IDLE);
    assign valid = (state == DONE) || (state == DONE_ERROR);
    assign error = (state == DONE_ERROR);

    assign check_cycle = count[XLEN];
    assign fits        = {{XLEN{1'b0}}, remainder} >= shifted_divisor;

    // ########################################################################
    // State register
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= DIVIDE;
                    end
                end
                DIVIDE: begin
                    if (check_cycle) begin
                        if (divisor_q == '0) begin
                            state <= DONE_ERROR;
                        end else if (divisor_q > remainder) begin
                            state <= DONE;  // Quotient is zero.
                        end
                    end else if (count[0]) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ########################################################################
    // Datapath
    // ########################################################################

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    remainder       <= job.dividend_mag;
                    quotient        <= '0;
                    divisor_q       <= job.divisor_mag;
                    shifted_divisor <= {1'b0, job.divisor_mag, {(XLEN-1){1'b0}}};
                    count           <= {1'b1, {XLEN{1'b0}}};
                    fix_out         <= fix_in;
                end
            end
            DIVIDE: begin
                if (check_cycle) begin
                    if (divisor_q == '0) begin
                        quotient <= '1;  // Remainder already holds the dividend.
                    end
                end else begin
                    if (fits) begin
                        remainder <= remainder - shifted_divisor[XLEN-1:0];
                        quotient  <= quotient | count[XLEN-1:0];
                    end
                    shifted_divisor <= shifted_divisor >> 1;
                end
                count <= count >> 1;
            end
            default: ;
        endcase
    end

    a_valid_one_cycle: assert property (
        @(posedge clk) disable iff (rst) valid |=> !valid
    );

    a_error_is_valid: assert property (
        @(posedge clk) disable iff (rst) error |-> valid
    );

    a_ready_not_valid: assert property (
        @(posedge clk) disable iff (rst) !(ready && valid)
    );

endmodule

`default_nettype wire

// ==== design/rv_div_pkg.sv ====
`default_nettype none
`include "div_cfg.svh"

package rv_div_pkg;

    // ########################################################################
    // Operation codes, equal to funct3[1:0] of the M extension divides.
    // ########################################################################

    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,  // Signed quotient.
        OP_DIVU = 2'b01,  // Unsigned quotient.
        OP_REM  = 2'b10,  // Signed remainder.
        OP_REMU = 2'b11   // Unsigned remainder.
    } div_op_e;

    // ########################################################################
    // Request and response as seen by the issue and writeback stages.
    // ########################################################################

    typedef struct packed {
        div_op_e                 op;
        logic [`DIV_TAG_W-1:0]   tag;       // Destination register.
        logic [`DIV_XLEN-1:0]    dividend;  // rs1.
        logic [`DIV_XLEN-1:0]    divisor;   // rs2.
    } div_req_t;

    typedef struct packed {
        logic [`DIV_TAG_W-1:0]   tag;
        logic [`DIV_XLEN-1:0]    result;
        logic                    div_zero;  // Divisor was zero.
    } div_resp_t;

endpackage

`default_nettype wire

// ==== div_unit.f ====
+incdir+design
design/rv_div_pkg.sv
design/div_core_pkg.sv
design/div_operand_prep.sv
design/div_unsigned_core.sv
design/div_result_fix.sv
design/div_unit.sv
testbench/tb_div_unit.sv

// ==== testbench/tb_div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module tb_div_unit
    import rv_div_pkg::*;
();

    localparam int XLEN       = `DIV_XLEN;
    localparam int TAG_W      = `DIV_TAG_W;
    localparam int WAIT_MAX   = 100;
    localparam int LAT_SHORT  = 3;
    localparam int LAT_LONG   = XLEN + 3;
    localparam int NUM_RANDOM = 200;

    typedef struct packed {
        div_op_e         op;
        logic [XLEN-1:0] dividend;
        logic [XLEN-1:0] divisor;
        logic [XLEN-1:0] result;
        logic            div_zero;
    } vec_t;

    logic      clk;
    logic      rst;
    logic      start;
    div_req_t  req;
    logic      ready;
    logic      done;
    div_resp_t resp;

    vec_t        vectors[$];
    int          errors;
    int          requests;
    int          done_pulses;
    logic [31:0] rng_state;

    div_unit dut0 (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .req   (req),
        .ready (ready),
        .done  (done),
        .resp  (resp)
    );

    always #4 clk = ~clk;  // 8 ns period.

    always @(negedge clk) begin
        if (!rst && done) begin
            done_pulses = done_pulses + 1;
        end
    end

    // ########################################################################
    // Compare tasks
    // ########################################################################

    task automatic check_result(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
                             input logic [TAG_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ########################################################################
    // Reference model and random source
    // ########################################################################

    function automatic logic [XLEN-1:0] model_result(input div_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] sq;
        logic signed [XLEN-1:0] sr;
        logic                   overflow;
        sa       = a;
        sb       = b;
        overflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        if (op == OP_DIVU) begin
            return (b == '0) ? '1 : a / b;
        end
        if (op == OP_REMU) begin
            return (b == '0) ? a : a % b;
        end
        if (op == OP_DIV) begin
            if (b == '0) begin
                return '1;
            end
            if (overflow) begin
                return a;
            end
            sq = sa / sb;  // Truncates toward zero.
            return sq;
        end
        if (b == '0) begin
            return a;
        end
        if (overflow) begin
            return '0;
        end
        sr = sa % sb;  // Sign of the dividend.
        return sr;
    endfunction

    // Short path when the divisor magnitude is zero or above the dividend magnitude.
    function automatic int model_latency(input div_op_e op, input logic [XLEN-1:0] a,
                                         input logic [XLEN-1:0] b);
        logic            signed_op;
        logic [XLEN-1:0] mag_a;
        logic [XLEN-1:0] mag_b;
        signed_op = (op == OP_DIV) || (op == OP_REM);
        mag_a     = (signed_op && a[XLEN-1]) ? -a : a;
        mag_b     = (signed_op && b[XLEN-1]) ? -b : b;
        if ((mag_b == '0) || (mag_b > mag_a)) begin
            return LAT_SHORT;
        end
        return LAT_LONG;
    endfunction

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic void add_row(input div_op_e op, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b, input logic [XLEN-1:0] res,
                                    input logic zero);
        vec_t row;
        row.op       = op;
        row.dividend = a;
        row.divisor  = b;
        row.result   = res;
        row.div_zero = zero;
        vectors.push_back(row);
    endfunction

    function automatic void build_table();
        add_row(OP_DIVU, 32'd100,       32'd7,         32'd14,        1'b0);
        add_row(OP_REMU, 32'd100,       32'd7,         32'd2,         1'b0);
        add_row(OP_DIVU, 32'd3,         32'd10,        32'd0,         1'b0);  // Short path.
        add_row(OP_REMU, 32'd3,         32'd10,        32'd3,         1'b0);
        add_row(OP_DIVU, 32'hFFFFFFFF,  32'd1,         32'hFFFFFFFF,  1'b0);
        add_row(OP_REMU, 32'hFFFFFFFF,  32'h10,        32'hF,         1'b0);
        add_row(OP_DIVU, 32'h80000000,  32'hFFFFFFFF,  32'd0,         1'b0);
        add_row(OP_DIV,  32'd20,        32'd6,         32'd3,         1'b0);
        add_row(OP_DIV,  32'hFFFFFFEC,  32'd6,         32'hFFFFFFFD,  1'b0);
        add_row(OP_DIV,  32'd20,        32'hFFFFFFFA,  32'hFFFFFFFD,  1'b0);
        add_row(OP_DIV,  32'hFFFFFFEC,  32'hFFFFFFFA,  32'd3,         1'b0);
        add_row(OP_REM,  32'd20,        32'd6,         32'd2,         1'b0);
        add_row(OP_REM,  32'hFFFFFFEC,  32'd6,         32'hFFFFFFFE,  1'b0);
        add_row(OP_REM,  32'd20,        32'hFFFFFFFA,  32'd2,         1'b0);
        add_row(OP_REM,  32'hFFFFFFEC,  32'hFFFFFFFA,  32'hFFFFFFFE,  1'b0);
        add_row(OP_DIV,  32'h80000000,  32'd2,         32'hC0000000,  1'b0);
        add_row(OP_DIV,  32'd1234,      32'd0,         32'hFFFFFFFF,  1'b1);  // Divide by zero.
        add_row(OP_DIV,  32'hFFFFFFFB,  32'd0,         32'hFFFFFFFF,  1'b1);
        add_row(OP_DIVU, 32'hDEADBEEF,  32'd0,         32'hFFFFFFFF,  1'b1);
        add_row(OP_REM,  32'hFFFFFFFB,  32'd0,         32'hFFFFFFFB,  1'b1);
        add_row(OP_REMU, 32'hDEADBEEF,  32'd0,         32'hDEADBEEF,  1'b1);
        add_row(OP_DIV,  32'h80000000,  32'hFFFFFFFF,  32'h80000000,  1'b0);  // Overflow.
        add_row(OP_REM,  32'h80000000,  32'hFFFFFFFF,  32'd0,         1'b0);
    endfunction

    // ########################################################################
    // Handshake tasks, all entered and left on a falling edge
    // ########################################################################

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            errors++;
            $display("Timeout: ready never came back high within %0d cycles", WAIT_MAX);
        end
    endtask

    task automatic issue(input div_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [TAG_W-1:0] tag);
        start        = 1'b1;
        req.op       = op;
        req.tag      = tag;
        req.dividend = a;
        req.divisor  = b;
        @(negedge clk);  // Accepted on the edge in between.
        start = 1'b0;
        requests++;
    endtask

    // Cycles counts rising edges since acceptance.
    task automatic wait_done(output int cycles);
        cycles = 0;
        while (!done && cycles < WAIT_MAX) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("Timeout: done never came within %0d cycles", WAIT_MAX);
        end
    endtask

    task automatic run_vector(input div_op_e op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp,
                              input logic zero, input logic [TAG_W-1:0] tag);
        int cycles;
        wait_ready();
        issue(op, a, b, tag);
        wait_done(cycles);
        check_result("resp.result", resp.result, exp);
        check_tag("resp.tag", resp.tag, tag);
        check_flag("resp.div_zero", resp.div_zero, zero);
        check_count("done latency", cycles, model_latency(op, a, b));
    endtask

    // Second request while the core is busy, then stray starts while ready is low.
    task automatic run_overlap();
        logic [XLEN-1:0] a0;
        logic [XLEN-1:0] b0;
        logic [XLEN-1:0] a1;
        logic [XLEN-1:0] b1;
        int              cycles;
        a0 = 32'h76543210;
        b0 = 32'h00000123;
        a1 = 32'hFFFFFF9C;
        b1 = 32'd7;
        wait_ready();
        issue(OP_DIVU, a0, b0, 5'd3);
        check_flag("ready", ready, 1'b1);  // Entry drains into the idle core.
        issue(OP_REM, a1, b1, 5'd4);
        req.op  = OP_DIV;
        req.tag = 5'd31;
        start   = 1'b1;
        repeat (4) begin
            check_flag("ready", ready, 1'b0);
            @(negedge clk);
        end
        start = 1'b0;
        wait_done(cycles);
        check_tag("resp.tag", resp.tag, 5'd3);
        check_result("resp.result", resp.result, model_result(OP_DIVU, a0, b0));
        @(negedge clk);
        wait_done(cycles);
        check_tag("resp.tag", resp.tag, 5'd4);
        check_result("resp.result", resp.result, model_result(OP_REM, a1, b1));
    endtask

    // ########################################################################
    // Main sequence
    // ########################################################################

    initial begin
        int              i;
        logic [31:0]     r;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        div_op_e         op;
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        req         = '0;
        errors      = 0;
        requests    = 0;
        done_pulses = 0;
        rng_state   = 32'd2;
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_flag("ready", ready, 1'b1);

        for (i = 0; i < vectors.size(); i++) begin
            run_vector(vectors[i].op, vectors[i].dividend, vectors[i].divisor,
                       vectors[i].result, vectors[i].div_zero, i[TAG_W-1:0]);
        end

        for (i = 0; i < NUM_RANDOM; i++) begin
            r  = next_random();
            a  = next_random();
            b  = next_random();
            op = div_op_e'(r[1:0]);
            if (r[7:4] == 4'd0) begin
                b = '0;
            end else begin
                b = b >> r[12:8];  // Smaller divisors reach the long path.
            end
            if (r[15:13] == 3'd0) begin
                a = a >> r[20:16];
            end
            run_vector(op, a, b, model_result(op, a, b), b == '0, r[28:24]);
        end

        run_overlap();
        repeat (5) @(negedge clk);
        check_count("done pulses", done_pulses, requests);

        $display("Run complete: %0d errors, %0d requests, %0d done pulses",
                 errors, requests, done_pulses);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
